// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/rd_write_if.sv
  - rtl/stage_reg.sv
  - rtl/pc_fetch.sv
  - rtl/decode.sv
  - rtl/reg_file.sv
  - rtl/execute.sv
  - rtl/mem_access.sv
  - rtl/hazard_ctrl.sv
  - rtl/rv_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_core.sv

// ==== rtl/decode.sv ====
// instruction decode with immediate generation and operand selection
module decode #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  rv_pkg::if_id_t    if_id_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    input  rv_pkg::xlen_t     rs1_data_i,
    input  rv_pkg::xlen_t     rs2_data_i,
    output rv_pkg::id_ex_t    id_ex_o
);

    rv_pkg::inst_t     inst;
    rv_pkg::opcode_e   opcode;
    rv_pkg::reg_addr_t rd;
    logic [2:0]        funct3;
    logic [xlen-1:0]   imm_i;
    logic [xlen-1:0]   imm_s;
    logic [xlen-1:0]   imm_b;
    logic [xlen-1:0]   imm_j;
    logic [xlen-1:0]   imm_u;

    assign inst   = if_id_i.inst;
    assign opcode = rv_pkg::opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1_o  = inst[19:15];
    assign rs2_o  = inst[24:20];

    // sign-extended immediates
    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        id_ex_o            = '0;
        id_ex_o.valid      = if_id_i.valid;
        id_ex_o.pc         = if_id_i.pc;
        id_ex_o.op1        = rs1_data_i;
        id_ex_o.op2        = rs2_data_i;
        id_ex_o.store_data = rs2_data_i;
        id_ex_o.rd         = rd;
        case (opcode)
            rv_pkg::OP: begin
                id_ex_o.reg_wen = 1'b1;
                case (funct3)
                    3'b000: id_ex_o.alu_op = inst[30] ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b100: id_ex_o.alu_op = rv_pkg::XOR;
                    3'b110: id_ex_o.alu_op = rv_pkg::OR;
                    3'b111: id_ex_o.alu_op = rv_pkg::AND;
                    default: id_ex_o.reg_wen = 1'b0;
                endcase
            end
            rv_pkg::OP_IMM: begin
                // only ADDI
                id_ex_o.op2     = imm_i;
                id_ex_o.imm     = imm_i;
                id_ex_o.reg_wen = (funct3 == 3'b000);
            end
            rv_pkg::LUI: begin
                id_ex_o.op2     = imm_u;
                id_ex_o.imm     = imm_u;
                id_ex_o.alu_op  = rv_pkg::PASS_B;
                id_ex_o.reg_wen = 1'b1;
            end
            rv_pkg::LOAD: begin
                id_ex_o.op2     = imm_i;
                id_ex_o.imm     = imm_i;
                id_ex_o.is_load = (funct3 == 3'b011);
                id_ex_o.reg_wen = (funct3 == 3'b011);
            end
            rv_pkg::STORE: begin
                id_ex_o.op2      = imm_s;
                id_ex_o.imm      = imm_s;
                id_ex_o.is_store = (funct3 == 3'b011);
            end
            rv_pkg::BRANCH: begin
                id_ex_o.imm          = imm_b;
                id_ex_o.is_branch_eq = (funct3 == 3'b000);
                id_ex_o.is_branch_ne = (funct3 == 3'b001);
            end
            rv_pkg::JAL: begin
                id_ex_o.imm     = imm_j;
                id_ex_o.reg_wen = 1'b1;
                id_ex_o.is_jal  = 1'b1;
            end
            default: begin
                // unsupported opcode travels as a bubble
                id_ex_o.reg_wen = 1'b0;
            end
        endcase
        // x0 writes never reach bypass or commit
        if (rd == '0) begin
            id_ex_o.reg_wen = 1'b0;
        end
    end

endmodule

// ==== rtl/execute.sv ====
// ALU, branch and jump resolution, load and store address generation
module execute #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  rv_pkg::id_ex_t  id_ex_i,
    output rv_pkg::ex_mem_t ex_mem_o,
    output logic            redirect_en_o,
    output rv_pkg::xlen_t   redirect_pc_o,
    rd_write_if.source      ex_bus
);

    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] link_pc;
    logic [xlen-1:0] result;
    logic            operands_eq;
    logic            taken;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::SUB:    alu_res = id_ex_i.op1 - id_ex_i.op2;
            rv_pkg::AND:    alu_res = id_ex_i.op1 & id_ex_i.op2;
            rv_pkg::OR:     alu_res = id_ex_i.op1 | id_ex_i.op2;
            rv_pkg::XOR:    alu_res = id_ex_i.op1 ^ id_ex_i.op2;
            rv_pkg::PASS_B: alu_res = id_ex_i.op2;
            default:        alu_res = id_ex_i.op1 + id_ex_i.op2;
        endcase
    end

    // branches compare rs1 against the rs2 value carried as store data
    assign operands_eq = (id_ex_i.op1 == id_ex_i.store_data);
    assign taken = (id_ex_i.is_branch_eq && operands_eq)
                 || (id_ex_i.is_branch_ne && !operands_eq)
                 || id_ex_i.is_jal;

    assign redirect_en_o = id_ex_i.valid && taken;
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    assign link_pc = id_ex_i.pc + xlen'(4);
    assign result  = id_ex_i.is_jal ? link_pc : alu_res;

    assign ex_mem_o.valid      = id_ex_i.valid;
    assign ex_mem_o.pc         = id_ex_i.pc;
    assign ex_mem_o.result     = result;
    assign ex_mem_o.store_data = id_ex_i.store_data;
    assign ex_mem_o.rd         = id_ex_i.rd;
    assign ex_mem_o.reg_wen    = id_ex_i.reg_wen;
    assign ex_mem_o.is_load    = id_ex_i.is_load;
    assign ex_mem_o.is_store   = id_ex_i.is_store;

    // load data arrives one stage later and hazard_ctrl covers that gap
    assign ex_bus.wen     = id_ex_i.valid && id_ex_i.reg_wen && !id_ex_i.is_load;
    assign ex_bus.rd_addr = id_ex_i.rd;
    assign ex_bus.rd_data = result;
    assign ex_bus.pc      = id_ex_i.pc;

endmodule

// ==== rtl/hazard_ctrl.sv ====
// pipeline control for jump flushes and load-use stalls
module hazard_ctrl (
    input  logic              clk_i,
    input  logic              reset_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              ex_is_load_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  logic              redirect_en_i,
    output logic              pc_stall_o,
    output logic              if_id_stall_o,
    output logic              if_id_flush_o,
    output logic              id_ex_flush_o
);

    logic load_use;

    assign load_use = ex_is_load_i && (ex_rd_i != '0)
                    && ((ex_rd_i == rs1_i) || (ex_rd_i == rs2_i));

    // hold fetch and decode, push a bubble into execute
    assign pc_stall_o    = load_use;
    assign if_id_stall_o = load_use;

    // taken branch or jump kills the two younger instructions
    assign if_id_flush_o = redirect_en_i;
    assign id_ex_flush_o = redirect_en_i || load_use;

    // the bubble leaves no load in execute on the next cycle
    a_stall_one_cycle : assert property (
        @(posedge clk_i) disable iff (reset_i)
        pc_stall_o |=> !pc_stall_o
    ) else $error("load-use stall lasted more than one cycle");

endmodule

// ==== rtl/mem_access.sv ====
// data memory access and writeback data select
module mem_access #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  rv_pkg::ex_mem_t ex_mem_i,
    output logic            dmem_ren_o,
    output logic            dmem_wen_o,
    output rv_pkg::xlen_t   dmem_addr_o,
    output rv_pkg::xlen_t   dmem_wdata_o,
    input  rv_pkg::xlen_t   dmem_rdata_i,
    output rv_pkg::mem_wb_t mem_wb_o,
    rd_write_if.source      mem_bus
);

    logic [xlen-1:0] wdata;

    assign dmem_ren_o   = ex_mem_i.valid && ex_mem_i.is_load;
    assign dmem_wen_o   = ex_mem_i.valid && ex_mem_i.is_store;
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;

    assign wdata = ex_mem_i.is_load ? dmem_rdata_i : ex_mem_i.result;

    assign mem_wb_o.valid   = ex_mem_i.valid;
    assign mem_wb_o.pc      = ex_mem_i.pc;
    assign mem_wb_o.rd      = ex_mem_i.rd;
    assign mem_wb_o.wdata   = wdata;
    assign mem_wb_o.reg_wen = ex_mem_i.reg_wen;

    assign mem_bus.wen     = ex_mem_i.valid && ex_mem_i.reg_wen;
    assign mem_bus.rd_addr = ex_mem_i.rd;
    assign mem_bus.rd_data = wdata;
    assign mem_bus.pc      = ex_mem_i.pc;

    // decode must never mark one instruction as both load and store
    a_rw_exclusive : assert final (!(dmem_ren_o && dmem_wen_o))
        else $error("data memory read and write enabled together");

endmodule

// ==== rtl/pc_fetch.sv ====
// program counter with jump redirect and instruction fetch
module pc_fetch #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           redirect_en_i,
    input  rv_pkg::xlen_t  redirect_pc_i,
    output rv_pkg::xlen_t  imem_addr_o,
    input  rv_pkg::inst_t  imem_rdata_i,
    output rv_pkg::if_id_t if_id_o
);

    logic [xlen-1:0] pc_q;

    // redirect from execute overrides a load-use stall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= rv_pkg::RESET_PC;
        end else if (redirect_en_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + xlen'(4);
        end
    end

    assign imem_addr_o   = pc_q;
    assign if_id_o.valid = 1'b1;
    assign if_id_o.pc    = pc_q;
    assign if_id_o.inst  = imem_rdata_i;

    // jump targets computed in execute must keep word alignment
    a_pc_aligned : assert property (
        @(posedge clk_i) disable iff (reset_i)
        pc_q[1:0] == 2'b00
    ) else $error("fetch address 0x%0h not 4-byte aligned", pc_q);

endmodule

// ==== rtl/rd_write_if.sv ====
// destination register write as seen by bypass and writeback
interface rd_write_if;

    logic              wen;
    rv_pkg::reg_addr_t rd_addr;
    rv_pkg::xlen_t     rd_data;
    rv_pkg::xlen_t     pc;

    modport source (
        output wen,
        output rd_addr,
        output rd_data,
        output pc
    );

    modport sink (
        input wen,
        input rd_addr,
        input rd_data,
        input pc
    );

endinterface

// ==== rtl/reg_file.sv ====
// integer register file with bypass from execute, mem and writeback
module reg_file #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::xlen_t     rs1_data_o,
    output rv_pkg::xlen_t     rs2_data_o,
    rd_write_if.sink          ex_bus,
    rd_write_if.sink          mem_bus,
    rd_write_if.sink          wb_bus
);

    logic [xlen-1:0]   regs_q [32];
    rv_pkg::reg_addr_t rs     [2];
    logic [xlen-1:0]   rdata  [2];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_bus.wen) begin
            regs_q[wb_bus.rd_addr] <= wb_bus.rd_data;
        end
    end

    assign rs[0] = rs1_i;
    assign rs[1] = rs2_i;

    // youngest producer wins and writeback covers the write-through case
    for (genvar p = 0; p < 2; p++) begin : g_read
        always_comb begin
            if (rs[p] == '0) begin
                rdata[p] = '0;
            end else if (ex_bus.wen && ex_bus.rd_addr == rs[p]) begin
                rdata[p] = ex_bus.rd_data;
            end else if (mem_bus.wen && mem_bus.rd_addr == rs[p]) begin
                rdata[p] = mem_bus.rd_data;
            end else if (wb_bus.wen && wb_bus.rd_addr == rs[p]) begin
                rdata[p] = wb_bus.rd_data;
            end else begin
                rdata[p] = regs_q[rs[p]];
            end
        end
    end

    assign rs1_data_o = rdata[0];
    assign rs2_data_o = rdata[1];

endmodule

// ==== rtl/rv_core.sv ====
// five-stage in-order RV64 integer pipeline top level
module rv_core #(
    parameter int unsigned xlen = rv_pkg::XLEN
) (
    input  logic              clk_i,
    input  logic              reset_i,
    // instruction memory
    output rv_pkg::xlen_t     imem_addr_o,
    input  rv_pkg::inst_t     imem_rdata_i,
    // data memory
    output logic              dmem_ren_o,
    output logic              dmem_wen_o,
    output rv_pkg::xlen_t     dmem_addr_o,
    output rv_pkg::xlen_t     dmem_wdata_o,
    input  rv_pkg::xlen_t     dmem_rdata_i,
    // writeback trace
    output logic              commit_valid_o,
    output rv_pkg::xlen_t     commit_pc_o,
    output rv_pkg::reg_addr_t commit_rd_o,
    output rv_pkg::xlen_t     commit_data_o
);

    rv_pkg::if_id_t    if_id_d;
    rv_pkg::if_id_t    if_id_q;
    rv_pkg::id_ex_t    id_ex_d;
    rv_pkg::id_ex_t    id_ex_q;
    rv_pkg::ex_mem_t   ex_mem_d;
    rv_pkg::ex_mem_t   ex_mem_q;
    rv_pkg::mem_wb_t   mem_wb_d;
    rv_pkg::mem_wb_t   mem_wb_q;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;
    rv_pkg::xlen_t     redirect_pc;
    logic              redirect_en;
    logic              pc_stall;
    logic              if_id_stall;
    logic              if_id_flush;
    logic              id_ex_flush;

    rd_write_if ex_bus ();
    rd_write_if mem_bus ();
    rd_write_if wb_bus ();

    pc_fetch #(.xlen(xlen)) pc_fetch_inst (
        .clk_i         ( clk_i        ),
        .reset_i       ( reset_i      ),
        .stall_i       ( pc_stall     ),
        .redirect_en_i ( redirect_en  ),
        .redirect_pc_i ( redirect_pc  ),
        .imem_addr_o   ( imem_addr_o  ),
        .imem_rdata_i  ( imem_rdata_i ),
        .if_id_o       ( if_id_d      )
    );

    stage_reg #(.payload_t(rv_pkg::if_id_t)) if_id_inst (
        .clk_i   ( clk_i       ),
        .reset_i ( reset_i     ),
        .stall_i ( if_id_stall ),
        .flush_i ( if_id_flush ),
        .d_i     ( if_id_d     ),
        .q_o     ( if_id_q     )
    );

    decode #(.xlen(xlen)) decode_inst (
        .if_id_i    ( if_id_q  ),
        .rs1_o      ( rs1      ),
        .rs2_o      ( rs2      ),
        .rs1_data_i ( rs1_data ),
        .rs2_data_i ( rs2_data ),
        .id_ex_o    ( id_ex_d  )
    );

    reg_file #(.xlen(xlen)) reg_file_inst (
        .clk_i      ( clk_i    ),
        .reset_i    ( reset_i  ),
        .rs1_i      ( rs1      ),
        .rs2_i      ( rs2      ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data ),
        .ex_bus     ( ex_bus   ),
        .mem_bus    ( mem_bus  ),
        .wb_bus     ( wb_bus   )
    );

    stage_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_inst (
        .clk_i   ( clk_i       ),
        .reset_i ( reset_i     ),
        .stall_i ( 1'b0        ),
        .flush_i ( id_ex_flush ),
        .d_i     ( id_ex_d     ),
        .q_o     ( id_ex_q     )
    );

    execute #(.xlen(xlen)) execute_inst (
        .id_ex_i       ( id_ex_q     ),
        .ex_mem_o      ( ex_mem_d    ),
        .redirect_en_o ( redirect_en ),
        .redirect_pc_o ( redirect_pc ),
        .ex_bus        ( ex_bus      )
    );

    hazard_ctrl hazard_ctrl_inst (
        .clk_i         ( clk_i           ),
        .reset_i       ( reset_i         ),
        .rs1_i         ( rs1             ),
        .rs2_i         ( rs2             ),
        .ex_is_load_i  ( id_ex_q.is_load ),
        .ex_rd_i       ( id_ex_q.rd      ),
        .redirect_en_i ( redirect_en     ),
        .pc_stall_o    ( pc_stall        ),
        .if_id_stall_o ( if_id_stall     ),
        .if_id_flush_o ( if_id_flush     ),
        .id_ex_flush_o ( id_ex_flush     )
    );

    // later stages never stall or flush
    stage_reg #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_inst (
        .clk_i   ( clk_i    ),
        .reset_i ( reset_i  ),
        .stall_i ( 1'b0     ),
        .flush_i ( 1'b0     ),
        .d_i     ( ex_mem_d ),
        .q_o     ( ex_mem_q )
    );

    mem_access #(.xlen(xlen)) mem_access_inst (
        .ex_mem_i     ( ex_mem_q     ),
        .dmem_ren_o   ( dmem_ren_o   ),
        .dmem_wen_o   ( dmem_wen_o   ),
        .dmem_addr_o  ( dmem_addr_o  ),
        .dmem_wdata_o ( dmem_wdata_o ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .mem_wb_o     ( mem_wb_d     ),
        .mem_bus      ( mem_bus      )
    );

    stage_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_inst (
        .clk_i   ( clk_i    ),
        .reset_i ( reset_i  ),
        .stall_i ( 1'b0     ),
        .flush_i ( 1'b0     ),
        .d_i     ( mem_wb_d ),
        .q_o     ( mem_wb_q )
    );

    // writeback feeds the register file and the trace port
    assign wb_bus.wen     = mem_wb_q.valid && mem_wb_q.reg_wen;
    assign wb_bus.rd_addr = mem_wb_q.rd;
    assign wb_bus.rd_data = mem_wb_q.wdata;
    assign wb_bus.pc      = mem_wb_q.pc;

    assign commit_valid_o = wb_bus.wen;
    assign commit_pc_o    = wb_bus.pc;
    assign commit_rd_o    = wb_bus.rd_addr;
    assign commit_data_o  = wb_bus.rd_data;

endmodule

// ==== rtl/rv_pkg.sv ====
// shared widths, encodings and stage payloads for the rv_core pipeline
package rv_pkg;

    localparam int unsigned XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    localparam xlen_t RESET_PC = '0;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // PASS_B forwards op2 untouched, used by LUI
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     store_data;
        xlen_t     imm;
        reg_addr_t rd;
        logic      reg_wen;
        alu_op_e   alu_op;
        logic      is_load;
        logic      is_store;
        logic      is_branch_eq;
        logic      is_branch_ne;
        logic      is_jal;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     result;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      reg_wen;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      reg_wen;
    } mem_wb_t;

endpackage

// ==== rtl/stage_reg.sv ====
// pipeline stage register with stall hold and flush to bubble
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // an all-zero payload has valid low
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    // the producing stage must hold its output while this stage is stalled
    a_stall_input_held : assert property (
        @(posedge clk_i) disable iff (reset_i)
        stall_i && !flush_i |=> $stable(d_i)
    ) else $error("stage input changed while stalled");

endmodule

// ==== sim/rv_ref_model.svh ====
// instruction-set model for rv_core with random program generator and in-order executor
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int PROG_LEN = 48;

typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LUI, K_LD, K_SD, K_BEQ, K_BNE, K_JAL
} kind_e;

// one extra slot holds the halt
kind_e             kind  [PROG_LEN+1];
rv_pkg::reg_addr_t rd_f  [PROG_LEN+1];
rv_pkg::reg_addr_t rs1_f [PROG_LEN+1];
rv_pkg::reg_addr_t rs2_f [PROG_LEN+1];
rv_pkg::xlen_t     imm_f [PROG_LEN+1];

// expected results in program order
rv_pkg::xlen_t     exp_pc      [$];
rv_pkg::reg_addr_t exp_rd      [$];
rv_pkg::xlen_t     exp_data    [$];
rv_pkg::xlen_t     exp_st_addr [$];
rv_pkg::xlen_t     exp_st_data [$];
int                n_taken;
int                n_loads;

function automatic void gen_program();
    logic [31:0] r;
    int          t;
    for (int i = 0; i < PROG_LEN; i++) begin
        kind[i]  = kind_e'($urandom_range(11, 0));
        rd_f[i]  = rv_pkg::reg_addr_t'($urandom_range(7, 1));
        rs1_f[i] = rv_pkg::reg_addr_t'($urandom_range(7, 0));
        rs2_f[i] = rv_pkg::reg_addr_t'($urandom_range(7, 0));
        // load result often used by the very next instruction
        if (i > 0 && kind[i-1] == K_LD && $urandom_range(1, 0) == 1) begin
            if ($urandom_range(1, 0) == 1) begin
                rs1_f[i] = rd_f[i-1];
            end else begin
                rs2_f[i] = rd_f[i-1];
            end
        end
        r = $urandom;
        t = i + $urandom_range(4, 1);
        if (t > PROG_LEN) begin
            t = PROG_LEN;
        end
        case (kind[i])
            K_LUI: imm_f[i] = {{32{r[31]}}, r[31:12], 12'h000};
            K_LD, K_SD: begin
                // doubleword slots 0 to 31 above x0
                rs1_f[i] = '0;
                imm_f[i] = rv_pkg::xlen_t'(r[4:0]) << 3;
            end
            K_BEQ, K_BNE, K_JAL: imm_f[i] = rv_pkg::xlen_t'((t - i) * 4);
            default: imm_f[i] = {{52{r[11]}}, r[11:0]};
        endcase
    end
    // jump to self ends the program
    kind[PROG_LEN]  = K_JAL;
    rd_f[PROG_LEN]  = '0;
    rs1_f[PROG_LEN] = '0;
    rs2_f[PROG_LEN] = '0;
    imm_f[PROG_LEN] = '0;
endfunction

function automatic rv_pkg::inst_t encode_inst(int i);
    logic [31:0]   im;
    rv_pkg::inst_t w;
    im = imm_f[i][31:0];
    case (kind[i])
        K_ADD:  w = {7'h00, rs2_f[i], rs1_f[i], 3'b000, rd_f[i], 7'h33};
        K_SUB:  w = {7'h20, rs2_f[i], rs1_f[i], 3'b000, rd_f[i], 7'h33};
        K_AND:  w = {7'h00, rs2_f[i], rs1_f[i], 3'b111, rd_f[i], 7'h33};
        K_OR:   w = {7'h00, rs2_f[i], rs1_f[i], 3'b110, rd_f[i], 7'h33};
        K_XOR:  w = {7'h00, rs2_f[i], rs1_f[i], 3'b100, rd_f[i], 7'h33};
        K_ADDI: w = {im[11:0], rs1_f[i], 3'b000, rd_f[i], 7'h13};
        K_LUI:  w = {im[31:12], rd_f[i], 7'h37};
        K_LD:   w = {im[11:0], 5'd0, 3'b011, rd_f[i], 7'h03};
        K_SD:   w = {im[11:5], rs2_f[i], 5'd0, 3'b011, im[4:0], 7'h23};
        K_BEQ:  w = {im[12], im[10:5], rs2_f[i], rs1_f[i], 3'b000, im[4:1], im[11], 7'h63};
        K_BNE:  w = {im[12], im[10:5], rs2_f[i], rs1_f[i], 3'b001, im[4:1], im[11], 7'h63};
        default: w = {im[20], im[10:1], im[11], im[19:12], rd_f[i], 7'h6f};
    endcase
    return w;
endfunction

function automatic void run_model();
    rv_pkg::xlen_t x   [32];
    rv_pkg::xlen_t mem [32];
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t res;
    int            idx;
    int            next;
    logic          wr;
    for (int r = 0; r < 32; r++) begin
        x[r]   = '0;
        mem[r] = '0;
    end
    n_taken = 0;
    n_loads = 0;
    idx     = 0;
    // control flow only goes forward, so the halt is always reached
    while (idx < PROG_LEN) begin
        a    = x[rs1_f[idx]];
        b    = x[rs2_f[idx]];
        res  = '0;
        wr   = 1'b1;
        next = idx + 1;
        case (kind[idx])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_ADDI: res = a + imm_f[idx];
            K_LUI:  res = imm_f[idx];
            K_LD: begin
                res = mem[imm_f[idx][7:3]];
                n_loads++;
            end
            K_SD: begin
                wr = 1'b0;
                mem[imm_f[idx][7:3]] = b;
                exp_st_addr.push_back(imm_f[idx]);
                exp_st_data.push_back(b);
            end
            K_BEQ, K_BNE: begin
                wr = 1'b0;
                if ((a == b) == (kind[idx] == K_BEQ)) begin
                    next = idx + int'(imm_f[idx] >> 2);
                    n_taken++;
                end
            end
            default: begin
                res  = rv_pkg::xlen_t'(idx * 4 + 4);
                next = idx + int'(imm_f[idx] >> 2);
                n_taken++;
            end
        endcase
        if (wr && rd_f[idx] != '0) begin
            x[rd_f[idx]] = res;
            exp_pc.push_back(rv_pkg::xlen_t'(idx * 4));
            exp_rd.push_back(rd_f[idx]);
            exp_data.push_back(res);
        end
        idx = next;
    end
endfunction

`endif

// ==== sim/tb_core.sv ====
// testbench for rv_core running random programs against an instruction-set model
module tb_core;

    localparam int          IMEM_WORDS   = 64;
    localparam int          NUM_PROGS    = 4;
    localparam int          RUN_TIMEOUT  = 2000;
    localparam int          QUIET_CYCLES = 30;
    localparam logic [31:0] SEED         = 32'h10fa00f4;

    logic              clk_i;
    logic              reset_i;
    rv_pkg::xlen_t     imem_addr_o;
    rv_pkg::inst_t     imem_rdata_i;
    logic              dmem_ren_o;
    logic              dmem_wen_o;
    rv_pkg::xlen_t     dmem_addr_o;
    rv_pkg::xlen_t     dmem_wdata_o;
    rv_pkg::xlen_t     dmem_rdata_i;
    logic              commit_valid_o;
    rv_pkg::xlen_t     commit_pc_o;
    rv_pkg::reg_addr_t commit_rd_o;
    rv_pkg::xlen_t     commit_data_o;

    rv_pkg::inst_t imem [IMEM_WORDS];
    rv_pkg::xlen_t dmem [32];
    int            errors;
    int            tests_failed;
    int            n_reads;

    `include "rv_ref_model.svh"

    rv_core #(.xlen(rv_pkg::XLEN)) dut (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .imem_addr_o    ( imem_addr_o    ),
        .imem_rdata_i   ( imem_rdata_i   ),
        .dmem_ren_o     ( dmem_ren_o     ),
        .dmem_wen_o     ( dmem_wen_o     ),
        .dmem_addr_o    ( dmem_addr_o    ),
        .dmem_wdata_o   ( dmem_wdata_o   ),
        .dmem_rdata_i   ( dmem_rdata_i   ),
        .commit_valid_o ( commit_valid_o ),
        .commit_pc_o    ( commit_pc_o    ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_data_o  ( commit_data_o  )
    );

    always #5 clk_i = ~clk_i;

    // both memories answer in the same cycle
    assign imem_rdata_i = imem[imem_addr_o[7:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:3]];

    always @(posedge clk_i) begin
        if (dmem_wen_o === 1'b1) begin
            dmem[dmem_addr_o[7:3]] <= dmem_wdata_o;
        end
    end

    task automatic compare_word(string name, rv_pkg::xlen_t got, rv_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_commit(rv_pkg::xlen_t got_pc, rv_pkg::reg_addr_t got_rd,
                                rv_pkg::xlen_t got_data, rv_pkg::xlen_t exp_pc_v,
                                rv_pkg::reg_addr_t exp_rd_v, rv_pkg::xlen_t exp_data_v);
        compare_word("commit_pc_o", got_pc, exp_pc_v);
        if (got_rd !== exp_rd_v) begin
            $display("Mismatch at %0t: commit_rd_o got x%0d expected x%0d",
                     $time, got_rd, exp_rd_v);
            errors++;
        end
        compare_word("commit_data_o", got_data, exp_data_v);
    endtask

    task automatic check_store(rv_pkg::xlen_t got_addr, rv_pkg::xlen_t got_data,
                               rv_pkg::xlen_t exp_addr, rv_pkg::xlen_t exp_data_v);
        compare_word("dmem_addr_o", got_addr, exp_addr);
        compare_word("dmem_wdata_o", got_data, exp_data_v);
    endtask

    // called mid-cycle when the trace and memory ports are settled
    task automatic sample_outputs();
        if (commit_valid_o !== 1'b0) begin
            if (exp_pc.size() == 0) begin
                $display("Extra commit at %0t from pc 0x%0h, none expected", $time, commit_pc_o);
                errors++;
            end else begin
                check_commit(commit_pc_o, commit_rd_o, commit_data_o,
                             exp_pc.pop_front(), exp_rd.pop_front(), exp_data.pop_front());
            end
        end
        if (dmem_wen_o !== 1'b0) begin
            if (exp_st_addr.size() == 0) begin
                $display("Extra store at %0t to 0x%0h, none expected", $time, dmem_addr_o);
                errors++;
            end else begin
                check_store(dmem_addr_o, dmem_wdata_o,
                            exp_st_addr.pop_front(), exp_st_data.pop_front());
            end
        end
        if (dmem_ren_o === 1'b1) begin
            n_reads++;
        end
    endtask

    function automatic void load_memories();
        for (int w = 0; w < IMEM_WORDS; w++) begin
            if (w <= PROG_LEN) begin
                imem[w] = encode_inst(w);
            end else begin
                imem[w] = '0;
            end
        end
        for (int d = 0; d < 32; d++) begin
            dmem[d] = '0;
        end
    endfunction

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i <= 1'b1;
        @(negedge clk_i);
        load_memories();
        for (int n = 0; n < 4; n++) begin
            @(posedge clk_i);
            if (n == 3) begin
                reset_i <= 1'b0;
            end
            @(negedge clk_i);
            compare_bit("commit_valid_o", commit_valid_o, 1'b0);
            compare_bit("dmem_wen_o", dmem_wen_o, 1'b0);
            compare_bit("dmem_ren_o", dmem_ren_o, 1'b0);
        end
        // first cycle out of reset
        compare_word("imem_addr_o", imem_addr_o, rv_pkg::RESET_PC);
    endtask

    task automatic run_program(int p);
        int start_errors;
        int n_commits;
        int n_stores;
        int cycles;
        start_errors = errors;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        gen_program();
        run_model();
        n_commits = exp_pc.size();
        n_stores  = exp_st_addr.size();
        apply_reset();
        n_reads = 0;
        cycles  = 0;
        while ((exp_pc.size() > 0 || exp_st_addr.size() > 0) && cycles < RUN_TIMEOUT) begin
            @(negedge clk_i);
            sample_outputs();
            cycles++;
        end
        if (exp_pc.size() > 0 || exp_st_addr.size() > 0) begin
            $display("Program %0d did not reach its halt within %0d cycles", p, RUN_TIMEOUT);
            errors++;
        end
        // halt loop must neither commit nor store
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk_i);
            sample_outputs();
            cycles++;
        end
        // each executed load reads the data memory exactly once
        if (n_reads != n_loads) begin
            $display("Mismatch at %0t: dmem_ren_o pulses got %0d expected %0d",
                     $time, n_reads, n_loads);
            errors++;
        end
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("program %0d: %0d commits, %0d stores, %0d loads, %0d taken jumps: %s",
                 p, n_commits, n_stores, n_loads, n_taken,
                 (errors == start_errors) ? "PASS" : "FAIL");
    endtask

    initial begin
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        errors       = 0;
        tests_failed = 0;
        n_reads      = 0;
        void'($urandom(SEED));
        for (int w = 0; w < IMEM_WORDS; w++) begin
            imem[w] = '0;
        end
        for (int d = 0; d < 32; d++) begin
            dmem[d] = '0;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_PROGS, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+sim
rtl/rv_pkg.sv
rtl/rd_write_if.sv
rtl/stage_reg.sv
rtl/pc_fetch.sv
rtl/decode.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/mem_access.sv
rtl/hazard_ctrl.sv
rtl/rv_core.sv
sim/tb_core.sv
